// ==== compile.f ====
memtest_pkg.sv
init_ram.sv
readback_checker.sv
report_link.sv
uart_tx.sv
uart_rx.sv
memtest_top.sv
memtest_assertions.sv
memtest_tb.sv

// ==== Makefile ====
TOP = memtest_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF ">>> PASS"

clean:
	rm -rf obj_dir

// ==== memtest_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module memtest_tb
    import memtest_pkg::*;
();

    localparam int clk_period = 8;
    localparam int byte_cycles = 10 * bit_cycles;
    localparam int frames_expected = 7;
    localparam int halt_bytes = 10;
    localparam longint timeout_ns =
        longint'(frames_expected * error_len + halt_bytes + 6) * byte_cycles * clk_period;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        rx = 1'b1;
    logic [15:0] sw = '0;
    wire         tx;
    wire  [15:0] led;

    byte_t       rx_q [$];
    byte_t       exp_q [$];
    logic [31:0] rng = 32'hfb8ed496;
    int          errors = 0;
    int          checks = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    loop_t       loops = '0;
    addr_t       bad_addr;
    word_t       bad_val;

    memtest_top dut0 (
        .clk (clk),
        .rst (rst),
        .rx  (rx),
        .tx  (tx),
        .sw  (sw),
        .led (led)
    );

    always #(clk_period / 2) clk = ~clk;

    initial begin : watchdog
        #(timeout_ns);
        $display("Timeout: the expected frames did not arrive in %0d ns", timeout_ns);
        $display(">>> FAIL");
        $finish;
    end

    // Decodes the DUT's serial output at the middle of each bit
    initial begin : serial_monitor
        byte_t b;
        forever begin
            @(negedge clk);
            if (!rst && tx == 1'b0) begin
                repeat (bit_cycles / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (bit_cycles) @(negedge clk);
                    b[i] = tx;
                end
                repeat (bit_cycles) @(negedge clk);
                if (tx !== 1'b1) begin
                    $display("Stop bit missing on tx at %0t", $time);
                    errors++;
                end
                rx_q.push_back(b);
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Expected report bytes in the order they leave the DUT
    function automatic void build_frame(input loop_t n, input bit corrupt, input addr_t a,
                                        input word_t val);
        word_t exp_word;
        exp_word = word_t'(a);
        exp_q.delete();
        if (!corrupt) begin
            exp_q.push_back(code_pass);
            exp_q.push_back(n);
        end else begin
            exp_q.push_back(code_error);
            exp_q.push_back(n);
            exp_q.push_back({7'b0, a[8]});
            exp_q.push_back(a[7:0]);
            for (int i = 3; i >= 0; i--) begin
                exp_q.push_back(exp_word[i*8 +: 8]);
            end
            // The eleven byte frame has room for three bytes of the read word
            exp_q.push_back(val[31:24]);
            exp_q.push_back(val[23:16]);
            exp_q.push_back(val[7:0]);
        end
    endfunction

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %s: expected %02h, actual %02h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_led(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %s: expected %04h, actual %04h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_silent(input string name);
        checks++;
        if (rx_q.size() != 0) begin
            $display("%s: %0d bytes arrived while the checker was halted", name, rx_q.size());
            errors++;
            test_errors++;
        end
    endtask

    task automatic next_rx_byte(output byte_t b);
        while (rx_q.size() == 0) begin
            @(posedge clk);
        end
        b = rx_q.pop_front();
    endtask

    task automatic corrupt_word();
        @(posedge clk);
        dut0.ram0.mem[bad_addr] <= bad_val;
    endtask

    task automatic expect_frame(input string name, input bit corrupt_after_head);
        byte_t b;
        for (int i = 0; i < exp_q.size(); i++) begin
            next_rx_byte(b);
            check_byte($sformatf("%s byte %0d", name, i), exp_q[i], b);
            // The next sweep starts only once the second byte goes out
            if (i == 0 && corrupt_after_head) begin
                corrupt_word();
            end
        end
    endtask

    task automatic send_byte(input byte_t b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (bit_cycles - 1) @(posedge clk);
        end
    endtask

    task automatic run_switch_patterns(input string name, input logic halted_exp, input int n);
        logic [15:0] pattern;
        for (int i = 0; i < n; i++) begin
            rng = xorshift32(rng);
            pattern = rng[15:0];
            @(posedge clk);
            sw <= pattern;
            @(posedge clk);
            @(negedge clk);
            check_led($sformatf("%s pattern %0d", name, i),
                      {halted_exp ^ pattern[15], pattern[14:0]}, led);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin : main_sequence
        byte_t other;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (int k = 0; k < 3; k++) begin
            build_frame(loops, 1'b0, '0, '0);
            expect_frame($sformatf("clean_sweeps frame %0d", k), 1'b0);
            loops++;
        end
        finish_test("clean_sweeps");

        rng = xorshift32(rng);
        bad_addr = rng[8:0];
        rng = xorshift32(rng);
        bad_val = rng;
        if (bad_val == word_t'(bad_addr)) begin
            bad_val[31] = 1'b1;
        end
        build_frame(loops, 1'b0, '0, '0);
        expect_frame("single_corruption lead", 1'b1);
        loops++;
        build_frame(loops, 1'b1, bad_addr, bad_val);
        expect_frame("single_corruption error", 1'b0);
        @(negedge clk);
        check_led("single_corruption led", 16'h8000, led);
        finish_test("single_corruption");

        repeat (halt_bytes * byte_cycles) @(posedge clk);
        check_silent("halt_holds");
        rng = xorshift32(rng);
        other = rng[7:0];
        if (other == code_resume) begin
            other = ~other;
        end
        send_byte(other);
        // Long enough for a wrongly restarted sweep to put a byte on tx
        repeat (2 * byte_cycles) @(posedge clk);
        @(negedge clk);
        check_led("halt_holds led", 16'h8000, led);
        check_silent("halt_holds after other byte");
        finish_test("halt_holds");

        run_switch_patterns("switches_halted", 1'b1, 8);
        finish_test("switches_halted");

        @(posedge clk);
        sw <= '0;
        dut0.ram0.mem[bad_addr] <= word_t'(bad_addr);
        send_byte(code_resume);
        // The failed sweep was not counted, so the count picks up where it stopped
        for (int k = 0; k < 2; k++) begin
            build_frame(loops, 1'b0, '0, '0);
            expect_frame($sformatf("resume frame %0d", k), 1'b0);
            loops++;
        end
        @(negedge clk);
        check_led("resume led", 16'h0000, led);
        finish_test("resume");

        run_switch_patterns("switches_running", 1'b0, 8);
        finish_test("switches_running");

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== memtest_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module memtest_assertions
    import memtest_pkg::*;
(
    input wire               clk,
    input wire               rst,
    input wire check_state_t state,
    input wire addr_t        read_addr,
    input wire               loop_done,
    input wire               error_found,
    input wire               report_busy,
    input wire               tx_busy,
    input wire               tx
);

    // A cycle spent in sweep that is followed by another one moves on by one word
    property addr_steps;
        @(posedge clk) disable iff (rst)
        state == chk_sweep |=> state != chk_sweep || read_addr == addr_t'($past(read_addr) + 1'b1);
    endproperty

    property no_pulse_while_busy;
        @(posedge clk) disable iff (rst)
        (loop_done || error_found) |-> !report_busy;
    endproperty

    property line_idle_high;
        @(posedge clk) disable iff (rst)
        !tx_busy |-> tx;
    endproperty

    assert property (addr_steps)
        else $error("read_addr did not step by one during a sweep");
    assert property (no_pulse_while_busy)
        else $error("checker pulsed while a report was still being sent");
    assert property (line_idle_high)
        else $error("tx left high level while the transmitter was idle");

endmodule

bind readback_checker memtest_assertions checker_asserts (
    .clk         (clk),
    .rst         (rst),
    .state       (state),
    .read_addr   (read_addr),
    .loop_done   (loop_done),
    .error_found (error_found),
    .report_busy (report_busy),
    .tx_busy     (1'b1),
    .tx          (1'b1)
);

bind uart_tx memtest_assertions tx_asserts (
    .clk         (clk),
    .rst         (rst),
    .state       (chk_idle),
    .read_addr   (addr_t'(0)),
    .loop_done   (1'b0),
    .error_found (1'b0),
    .report_busy (1'b0),
    .tx_busy     (busy),
    .tx          (tx)
);

`default_nettype wire

// ==== memtest_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module memtest_top
    import memtest_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire          rx,
    output logic         tx,
    input  wire [15:0]   sw,
    output logic [15:0]  led
);

    addr_t read_addr;
    word_t read_data;
    logic  loop_done;
    logic  error_found;
    loop_t loop_count;
    addr_t err_addr;
    word_t expected;
    word_t actual;
    logic  halted;
    logic  report_busy;
    logic  resume;
    logic  tx_valid;
    byte_t tx_byte;
    logic  tx_accept;
    logic  rx_strobe;
    byte_t rx_byte;

    init_ram ram0 (
        .clk       (clk),
        .read_addr (read_addr),
        .read_data (read_data)
    );

    readback_checker checker0 (
        .clk         (clk),
        .rst         (rst),
        .read_data   (read_data),
        .report_busy (report_busy),
        .resume      (resume),
        .read_addr   (read_addr),
        .loop_done   (loop_done),
        .error_found (error_found),
        .loop_count  (loop_count),
        .err_addr    (err_addr),
        .expected    (expected),
        .actual      (actual),
        .halted      (halted)
    );

    report_link link0 (
        .clk         (clk),
        .rst         (rst),
        .loop_done   (loop_done),
        .error_found (error_found),
        .loop_count  (loop_count),
        .err_addr    (err_addr),
        .expected    (expected),
        .actual      (actual),
        .halted      (halted),
        .tx_accept   (tx_accept),
        .rx_strobe   (rx_strobe),
        .rx_byte     (rx_byte),
        .sw          (sw),
        .report_busy (report_busy),
        .tx_valid    (tx_valid),
        .tx_byte     (tx_byte),
        .resume      (resume),
        .led         (led)
    );

    uart_tx tx0 (
        .clk       (clk),
        .rst       (rst),
        .tx_valid  (tx_valid),
        .tx_byte   (tx_byte),
        .tx_accept (tx_accept),
        .tx        (tx)
    );

    uart_rx rx0 (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .rx_strobe (rx_strobe),
        .rx_byte   (rx_byte)
    );

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx
    import memtest_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire          rx,
    output logic         rx_strobe,
    output byte_t        rx_byte
);

    logic       rx_meta;
    logic       rx_sync;
    logic [4:0] tick_cnt;
    logic       tick;
    logic       active;
    logic [2:0] os_cnt;
    logic [2:0] sample_point;
    logic [3:0] bit_idx;
    byte_t      shift;

    assign tick = (tick_cnt == 5'(baud_div - 1));

    // The start bit is checked half a bit in, every later bit a full bit on
    assign sample_point = (bit_idx == 4'd0) ? 3'(oversample / 2 - 1) : 3'(oversample - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            tick_cnt <= '0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            tick_cnt <= tick ? 5'd0 : tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            os_cnt <= '0;
            bit_idx <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            if (tick) begin
                if (!active) begin
                    if (!rx_sync) begin
                        active <= 1'b1;
                        os_cnt <= '0;
                        bit_idx <= '0;
                    end
                end else if (os_cnt == sample_point) begin
                    os_cnt <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 4'd0 && rx_sync) begin
                        active <= 1'b0;
                    end else if (bit_idx == 4'd9) begin
                        active <= 1'b0;
                        rx_strobe <= rx_sync;
                    end
                end else begin
                    os_cnt <= os_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tick && active && os_cnt == sample_point) begin
            if (bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
                shift <= {rx_sync, shift[7:1]};
            end
            if (bit_idx == 4'd9 && rx_sync) begin
                rx_byte <= shift;
            end
        end
    end

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx
    import memtest_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire          tx_valid,
    input  wire byte_t   tx_byte,
    output logic         tx_accept,
    output logic         tx
);

    logic       busy;
    logic [7:0] cyc_cnt;
    logic [3:0] bit_idx;

    // Remaining data bits with the stop bit behind them
    logic [8:0] shift;

    assign tx_accept = tx_valid && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            tx <= 1'b1;
            cyc_cnt <= '0;
            bit_idx <= '0;
        end else if (!busy) begin
            tx <= 1'b1;
            if (tx_valid) begin
                busy <= 1'b1;
                tx <= 1'b0;
                cyc_cnt <= '0;
                bit_idx <= '0;
            end
        end else if (cyc_cnt == 8'(bit_cycles - 1)) begin
            cyc_cnt <= '0;
            if (bit_idx == 4'd9) begin
                busy <= 1'b0;
                tx <= 1'b1;
            end else begin
                tx <= shift[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_accept) begin
            shift <= {1'b1, tx_byte};
        end else if (busy && cyc_cnt == 8'(bit_cycles - 1)) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

`default_nettype wire

// ==== report_link.sv ====
`timescale 1ns/100ps
`default_nettype none

module report_link
    import memtest_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire          loop_done,
    input  wire          error_found,
    input  wire loop_t   loop_count,
    input  wire addr_t   err_addr,
    input  wire word_t   expected,
    input  wire word_t   actual,
    input  wire          halted,
    input  wire          tx_accept,
    input  wire          rx_strobe,
    input  wire byte_t   rx_byte,
    input  wire [15:0]   sw,
    output logic         report_busy,
    output logic         tx_valid,
    output byte_t        tx_byte,
    output logic         resume,
    output logic [15:0]  led
);

    link_state_t state;
    byte_t       frame [error_len];
    logic [3:0]  byte_idx;
    logic [3:0]  frame_last;

    assign report_busy = (state != link_idle);
    assign tx_valid = (state == link_send);
    assign tx_byte = frame[byte_idx];

    always_ff @(posedge clk) begin
        if (state == link_idle) begin
            if (error_found) begin
                frame[0] <= code_error;
                frame[1] <= loop_count;
                frame[2] <= {7'b0, err_addr[8]};
                frame[3] <= err_addr[7:0];
                frame[4] <= expected[31:24];
                frame[5] <= expected[23:16];
                frame[6] <= expected[15:8];
                frame[7] <= expected[7:0];
                frame[8] <= actual[31:24];
                frame[9] <= actual[23:16];
                frame[10] <= actual[7:0];
            end else if (loop_done) begin
                frame[0] <= code_pass;
                frame[1] <= loop_count;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= link_idle;
            byte_idx <= '0;
            frame_last <= '0;
            resume <= 1'b0;
            led <= '0;
        end else begin
            resume <= rx_strobe && (rx_byte == code_resume) && halted;
            led <= {halted ^ sw[15], sw[14:0]};

            case (state)
                link_idle: begin
                    byte_idx <= '0;
                    if (error_found) begin
                        frame_last <= 4'(error_len - 1);
                        state <= link_send;
                    end else if (loop_done) begin
                        frame_last <= 4'(pass_len - 1);
                        state <= link_send;
                    end
                end
                link_send: begin
                    if (tx_accept) begin
                        if (byte_idx == frame_last) begin
                            state <= link_idle;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state <= link_wait_tx;
                        end
                    end
                end
                link_wait_tx: begin
                    state <= link_send;
                end
                default: begin
                    state <= link_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== readback_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module readback_checker
    import memtest_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire word_t   read_data,
    input  wire          report_busy,
    input  wire          resume,
    output addr_t        read_addr,
    output logic         loop_done,
    output logic         error_found,
    output loop_t        loop_count,
    output addr_t        err_addr,
    output word_t        expected,
    output word_t        actual,
    output logic         halted
);

    check_state_t state;

    // Address of the word now arriving on read_data
    addr_t addr_d;
    logic  rd_valid;
    logic  err_seen;
    logic  mismatch;
    word_t expected_word;

    assign expected_word = word_t'(addr_d);
    assign mismatch = rd_valid && (read_data != expected_word);
    assign halted = (state == chk_halted);

    always_ff @(posedge clk) begin
        addr_d <= read_addr;
        if (mismatch && !err_seen) begin
            err_addr <= addr_d;
            expected <= expected_word;
            actual <= read_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= chk_idle;
            read_addr <= '0;
            rd_valid <= 1'b0;
            err_seen <= 1'b0;
            loop_done <= 1'b0;
            error_found <= 1'b0;
            loop_count <= '0;
        end else begin
            rd_valid <= (state == chk_sweep);
            loop_done <= 1'b0;
            error_found <= 1'b0;

            // The pass frame carries the count before this sweep is added
            if (loop_done) begin
                loop_count <= loop_count + 1'b1;
            end

            // Only the first mismatch of a sweep is reported
            if (mismatch && !err_seen) begin
                error_found <= 1'b1;
                err_seen <= 1'b1;
            end else if (rd_valid && addr_d == max_addr && !err_seen) begin
                loop_done <= 1'b1;
            end

            case (state)
                chk_idle: begin
                    state <= chk_sweep;
                    read_addr <= '0;
                end
                chk_sweep: begin
                    if (read_addr == max_addr || mismatch) begin
                        state <= chk_wait_report;
                    end else begin
                        read_addr <= read_addr + 1'b1;
                    end
                end
                chk_wait_report: begin
                    // Let the pipeline drain and the report go out first
                    if (!rd_valid && !loop_done && !error_found && !report_busy) begin
                        if (err_seen) begin
                            state <= chk_halted;
                        end else begin
                            state <= chk_sweep;
                            read_addr <= '0;
                        end
                    end
                end
                chk_halted: begin
                    if (resume) begin
                        state <= chk_sweep;
                        read_addr <= '0;
                        err_seen <= 1'b0;
                    end
                end
                default: begin
                    state <= chk_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== init_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module init_ram
    import memtest_pkg::*;
(
    input  wire          clk,
    input  wire addr_t   read_addr,
    output word_t        read_data
);

    word_t mem [ram_depth];

    // Every word starts out holding its own address
    initial begin
        for (int i = 0; i < ram_depth; i++) begin
            mem[i] = word_t'(i);
        end
    end

    always_ff @(posedge clk) begin
        read_data <= mem[read_addr];
    end

endmodule

`default_nettype wire

// ==== memtest_pkg.sv ====
`default_nettype none

package memtest_pkg;

    typedef logic [8:0]  addr_t;
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  loop_t;

    localparam int ram_depth = 512;
    localparam addr_t max_addr = addr_t'(ram_depth - 1);

    // 25 cycles per tick and 8 ticks per bit give 200 cycles per bit
    localparam int baud_div = 25;
    localparam int oversample = 8;
    localparam int bit_cycles = baud_div * oversample;

    localparam int pass_len = 2;
    localparam int error_len = 11;

    localparam byte_t code_pass = 8'h50;
    localparam byte_t code_error = 8'h45;
    localparam byte_t code_resume = 8'h63;

    typedef enum logic [1:0] {
        chk_idle,
        chk_sweep,
        chk_wait_report,
        chk_halted
    } check_state_t;

    typedef enum logic [1:0] {
        link_idle,
        link_send,
        link_wait_tx
    } link_state_t;

endpackage

`default_nettype wire
